// ==== hw/cpuPkg.sv ====
package cpuPkg;

    // datapath and storage sizes.
    localparam int wordWidth       = 32;
    localparam int regCount        = 16;
    localparam int regIdxWidth     = $clog2(regCount);
    localparam int memWordsDefault = 512;

    // instruction field positions, all counted from bit 0 of the IR.
    localparam int opMsb  = 31;
    localparam int opLsb  = 27;
    localparam int raMsb  = 26;
    localparam int raLsb  = 23;
    localparam int rbMsb  = 22;
    localparam int rbLsb  = 19;
    localparam int rcMsb  = 18;
    localparam int rcLsb  = 15;
    localparam int cMsb   = 18;  // the constant runs from here down to bit 0.
    localparam int cWidth = 19;
    localparam int c2Msb  = 20;  // branch condition code.
    localparam int c2Lsb  = 19;

    // The opcode sits in the top five bits of every instruction.
    typedef enum logic [4:0] {
        opLd   = 5'd0,
        opLdi  = 5'd1,
        opSt   = 5'd2,
        opAdd  = 5'd3,
        opSub  = 5'd4,
        opShr  = 5'd5,
        opShl  = 5'd6,
        opAnd  = 5'd9,
        opOr   = 5'd10,
        opMul  = 5'd14,
        opNeg  = 5'd16,
        opNot  = 5'd17,
        opJal  = 5'd21,  // jal is 10101 in binary.
        opBrzr = 5'd24,
        opBrnz = 5'd25,
        opBrpl = 5'd26,
        opBrmi = 5'd27
    } opcode_t;

endpackage

// ==== hw/ctrlPkg.sv ====
package ctrlPkg;

    // what drives the shared bus during a step.
    typedef enum logic [2:0] {
        busNone   = 3'd0,  // bus reads as zero.
        busPc     = 3'd1,
        busZLow   = 3'd2,
        busZHigh  = 3'd3,
        busMdr    = 3'd4,
        busReg    = 3'd5,
        busCSign  = 3'd6
    } busSrc_t;

    // ALU operation selected for the step that has zIn set.
    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluShr   = 4'd4,
        aluShl   = 4'd5,
        aluNeg   = 4'd6,
        aluNot   = 4'd7,
        aluMul   = 4'd8,
        aluIncPc = 4'd9
    } aluOp_t;

    // One control step. The control unit drives a fresh word every clock.
    typedef struct packed {
        busSrc_t busSrc;
        logic    pcIn;
        logic    irIn;
        logic    marIn;
        logic    mdrIn;
        logic    yIn;
        logic    zIn;
        logic    gra;
        logic    grb;
        logic    grc;
        logic    rIn;
        logic    baOut;  // register 0 reads as zero for base addressing.
        logic    read;
        logic    write;
        aluOp_t  aluOp;
        logic    conIn;
    } ctrlWord_t;

endpackage

// ==== hw/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic                               clock,
    input  logic                               rstN,
    input  logic [cpuPkg::regIdxWidth-1:0]     index,
    input  logic                               writeEn,
    input  logic                               baOut,
    input  logic [cpuPkg::wordWidth-1:0]       writeData,
    output logic [cpuPkg::wordWidth-1:0]       readData
);
    import cpuPkg::*;

    logic [wordWidth-1:0] regs [regCount];
    logic                 baseZero;

    // A single index serves both the read and the write port, since the
    // select logic picks only one register per step.
    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[index] <= writeData;
        end
    end

    // in base-address mode r0 stands for the constant zero.
    assign baseZero = baOut && (index == '0);

    always_comb begin
        if (baseZero) begin
            readData = '0;
        end else begin
            readData = regs[index];
        end
    end

endmodule

// ==== hw/selectEncode.sv ====
`timescale 1ns/1ps

module selectEncode (
    input  logic [cpuPkg::wordWidth-1:0]       ir,
    input  logic                               gra,
    input  logic                               grb,
    input  logic                               grc,
    output logic [cpuPkg::regIdxWidth-1:0]     index,
    output logic [cpuPkg::wordWidth-1:0]       cSign
);
    import cpuPkg::*;

    logic [regIdxWidth-1:0] raField;
    logic [regIdxWidth-1:0] rbField;
    logic [regIdxWidth-1:0] rcField;

    assign raField = ir[raMsb:raLsb];
    assign rbField = ir[rbMsb:rbLsb];
    assign rcField = ir[rcMsb:rcLsb];

    // Only one of the three selects is expected per step.
    // gra wins if the control word asserts more than one.
    always_comb begin
        if (gra) begin
            index = raField;
        end else if (grb) begin
            index = rbField;
        end else if (grc) begin
            index = rcField;
        end else begin
            index = '0;  // no field selected.
        end
    end

    // the constant field overlaps rc, so it is only meaningful for
    // immediate, load, store and branch formats.
    assign cSign = {{(wordWidth - cWidth){ir[cMsb]}}, ir[cMsb:0]};

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  ctrlPkg::aluOp_t                    op,
    input  logic [cpuPkg::wordWidth-1:0]       a,
    input  logic [cpuPkg::wordWidth-1:0]       b,
    output logic [2*cpuPkg::wordWidth-1:0]     result
);
    import cpuPkg::*;
    import ctrlPkg::*;

    localparam int shiftBits = $clog2(wordWidth);

    logic [wordWidth-1:0]       low;      // result of the 32-bit operations.
    logic [shiftBits-1:0]       shamt;
    logic signed [2*wordWidth-1:0] product;

    assign shamt   = b[shiftBits-1:0];  // shift count wraps at the word size.
    assign product = $signed(a) * $signed(b);

    // a comes from Y and b is whatever sits on the bus this step.
    always_comb begin
        low = '0;
        case (op)
            aluAdd:   low = a + b;
            aluSub:   low = a - b;
            aluAnd:   low = a & b;
            aluOr:    low = a | b;
            aluShr:   low = a >> shamt;  // logical shift, zero fill.
            aluShl:   low = a << shamt;
            aluNeg:   low = '0 - b;      // unary ops take the bus operand.
            aluNot:   low = ~b;
            aluIncPc: low = b + 1'b1;
            default:  low = '0;
        endcase
    end

    // Multiply is the only operation that fills the upper half of Z.
    always_comb begin
        if (op == aluMul) begin
            result = product;
        end else begin
            result = {{wordWidth{1'b0}}, low};
        end
    end

endmodule

// ==== hw/conFf.sv ====
`timescale 1ns/1ps

module conFf (
    input  logic                               clock,
    input  logic                               rstN,
    input  logic                               conIn,
    input  logic [1:0]                         c2,
    input  logic [cpuPkg::wordWidth-1:0]       busData,
    output logic                               conFlag
);
    import cpuPkg::*;

    logic condMet;

    // c2 comes straight from the IR of the branch being executed.
    always_comb begin
        case (c2)
            2'd0:    condMet = (busData == '0);
            2'd1:    condMet = (busData != '0);
            2'd2:    condMet = ~busData[wordWidth-1];  // zero counts as positive here.
            default: condMet = busData[wordWidth-1];
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            conFlag <= 1'b0;
        end else if (conIn) begin
            conFlag <= condMet;  // held until the next branch evaluation.
        end
    end

endmodule

// ==== hw/memSubsystem.sv ====
`timescale 1ns/1ps

module memSubsystem #(
    parameter int memWords = cpuPkg::memWordsDefault
) (
    input  logic                               clock,
    input  logic                               rstN,
    input  logic                               marIn,
    input  logic                               mdrIn,
    input  logic                               read,
    input  logic                               write,
    input  logic [cpuPkg::wordWidth-1:0]       busData,
    input  logic                               loadEn,
    input  logic [8:0]                         loadAddr,
    input  logic [cpuPkg::wordWidth-1:0]       loadData,
    output logic [cpuPkg::wordWidth-1:0]       mdr
);
    import cpuPkg::*;

    localparam int addrWidth = $clog2(memWords);

    logic [addrWidth-1:0] mar;
    logic [wordWidth-1:0] ram [memWords];
    logic [wordWidth-1:0] ramRead;
    logic                 ramWe;
    logic [addrWidth-1:0] ramAddr;
    logic [wordWidth-1:0] ramWData;

    // memWords is a power of two, so dropping the upper bus bits wraps the address.
    always_ff @(posedge clock) begin
        if (!rstN) begin
            mar <= '0;
        end else if (marIn) begin
            mar <= busData[addrWidth-1:0];
        end
    end

    assign ramRead = ram[mar];  // asynchronous read, so a load finishes in one step.

    always_ff @(posedge clock) begin
        if (!rstN) begin
            mdr <= '0;
        end else if (mdrIn) begin
            mdr <= read ? ramRead : busData;
        end
    end

    // The external loader shares the single write port and takes priority.
    assign ramWe    = loadEn || write;
    assign ramAddr  = loadEn ? loadAddr[addrWidth-1:0] : mar;
    assign ramWData = loadEn ? loadData : mdr;

    always_ff @(posedge clock) begin
        if (ramWe) begin
            ram[ramAddr] <= ramWData;
        end
    end

endmodule

// ==== hw/dataPath.sv ====
`timescale 1ns/1ps

module dataPath #(
    parameter int memWords = cpuPkg::memWordsDefault
) (
    input  logic                               clock,
    input  logic                               rstN,
    input  ctrlPkg::ctrlWord_t                 ctrl,
    input  logic                               loadEn,
    input  logic [8:0]                         loadAddr,
    input  logic [cpuPkg::wordWidth-1:0]       loadData,
    output logic [cpuPkg::wordWidth-1:0]       busData,
    output logic                               conFlag
);
    import cpuPkg::*;
    import ctrlPkg::*;

    logic [wordWidth-1:0]   pc;
    logic [wordWidth-1:0]   ir;
    logic [wordWidth-1:0]   y;
    logic [2*wordWidth-1:0] z;

    logic [regIdxWidth-1:0] regIndex;
    logic [wordWidth-1:0]   regData;
    logic [wordWidth-1:0]   cSign;
    logic [wordWidth-1:0]   mdr;
    logic [2*wordWidth-1:0] aluResult;

    // Registers owned by the top level. Each one only ever loads from the
    // bus, apart from Z which captures the ALU output.
    always_ff @(posedge clock) begin
        if (!rstN) begin
            pc <= '0;
            ir <= '0;
            y  <= '0;
            z  <= '0;
        end else begin
            if (ctrl.pcIn) pc <= busData;
            if (ctrl.irIn) ir <= busData;
            if (ctrl.yIn)  y  <= busData;
            if (ctrl.zIn)  z  <= aluResult;  // full 64 bits, needed for mul.
        end
    end

    // the shared bus itself, one source per step.
    always_comb begin
        case (ctrl.busSrc)
            busPc:    busData = pc;
            busZLow:  busData = z[wordWidth-1:0];
            busZHigh: busData = z[2*wordWidth-1:wordWidth];
            busMdr:   busData = mdr;
            busReg:   busData = regData;
            busCSign: busData = cSign;
            default:  busData = '0;  // busNone leaves the bus at zero.
        endcase
    end

    selectEncode u_selectEncode (
        .ir    (ir),
        .gra   (ctrl.gra),
        .grb   (ctrl.grb),
        .grc   (ctrl.grc),
        .index (regIndex),
        .cSign (cSign)
    );

    regFile u_regFile (
        .clock     (clock),
        .rstN      (rstN),
        .index     (regIndex),
        .writeEn   (ctrl.rIn),
        .baOut     (ctrl.baOut),
        .writeData (busData),
        .readData  (regData)
    );

    // Y is always the first operand and the bus the second.
    alu u_alu (
        .op     (ctrl.aluOp),
        .a      (y),
        .b      (busData),
        .result (aluResult)
    );

    conFf u_conFf (
        .clock   (clock),
        .rstN    (rstN),
        .conIn   (ctrl.conIn),
        .c2      (ir[c2Msb:c2Lsb]),
        .busData (busData),
        .conFlag (conFlag)
    );

    memSubsystem #(
        .memWords (memWords)
    ) u_memSubsystem (
        .clock    (clock),
        .rstN     (rstN),
        .marIn    (ctrl.marIn),
        .mdrIn    (ctrl.mdrIn),
        .read     (ctrl.read),
        .write    (ctrl.write),
        .busData  (busData),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .mdr      (mdr)
    );

endmodule

// ==== sim/dataPathTests.svh ====
// PC to MAR, memory to MDR, MDR to IR, with PC incremented through Z.
task automatic runFetch();
    ctrlWord_t w;
    w = word(busPc);
    w.marIn = 1'b1;
    w.zIn = 1'b1;
    w.aluOp = aluIncPc;
    drive(w);
    w = word(busZLow);
    w.pcIn = 1'b1;
    w.read = 1'b1;
    w.mdrIn = 1'b1;
    drive(w);
    w = word(busMdr);
    w.irIn = 1'b1;
    drive(w);
endtask

// puts a word in IR through RAM address 0, which a zero bus selects.
task automatic setIr(logic [31:0] instr);
    ctrlWord_t w;
    loadMem(0, instr);
    w = word(busNone);
    w.marIn = 1'b1;
    drive(w);
    w = word(busNone);
    w.read = 1'b1;
    w.mdrIn = 1'b1;
    drive(w);
    w = word(busMdr);
    w.irIn = 1'b1;
    drive(w);
endtask

task automatic regWrite(int idx, logic [31:0] value);
    ctrlWord_t w;
    loadMem(16, value);
    setIr(mkInstr(opLd, idx, 0, 16));
    w = word(busCSign);
    w.marIn = 1'b1;
    drive(w);
    w = word(busNone);
    w.read = 1'b1;
    w.mdrIn = 1'b1;
    drive(w);
    w = word(busMdr);
    w.gra = 1'b1;
    w.rIn = 1'b1;
    drive(w);
endtask

// reads a register back through the rc field.
task automatic regRead(int idx, output logic [31:0] value);
    ctrlWord_t w;
    setIr(mkInstr(opAdd, 0, 0, idx << 15));
    w = word(busReg);
    w.grc = 1'b1;
    drive(w);
    value = busData;
endtask

task automatic testFetch();
    logic [31:0] instr;
    instr = mkInstr(opAdd, 3, 4, 5 << 15);
    loadMem(0, instr);
    runFetch();
    drive(word(busPc));
    check("fetch pc", busData, 1);
    drive(word(busMdr));
    check("fetch mdr", busData, instr);
    finishTest("fetch");
endtask

task automatic testAlu();
    ctrlWord_t   w;
    logic [31:0] a;
    logic [31:0] b;
    logic [63:0] exp;
    aluOp_t      op;
    for (int pass = 0; pass < 3; pass++) begin
        a = $random(seed);
        b = $random(seed);
        regWrite(1, a);
        regWrite(2, b);
        setIr(mkInstr(opAdd, 1, 2, 0));
        for (int i = 0; i <= 9; i++) begin
            op = aluOp_t'(i);
            exp = expAlu(op, a, b);
            w = word(busReg);
            w.gra = 1'b1;
            w.yIn = 1'b1;
            drive(w);
            w = word(busReg);
            w.grb = 1'b1;
            w.zIn = 1'b1;
            w.aluOp = op;
            drive(w);
            drive(word(busZLow));
            check({"zLow ", op.name()}, busData, exp[31:0]);
            if (op == aluMul) begin
                drive(word(busZHigh));
                check("zHigh mul", busData, exp[63:32]);
            end
        end
    end
    finishTest("alu");
endtask

// st or ld with the address rb + C formed in Z.
task automatic memAccess(bit isStore, int ra, int rb, int c, bit useBa);
    ctrlWord_t w;
    setIr(mkInstr(isStore ? opSt : opLd, ra, rb, c));
    w = word(busReg);
    w.grb = 1'b1;
    w.baOut = useBa;
    w.yIn = 1'b1;
    drive(w);
    w = word(busCSign);
    w.zIn = 1'b1;
    w.aluOp = aluAdd;
    drive(w);
    w = word(busZLow);
    w.marIn = 1'b1;
    drive(w);
    if (isStore) begin
        w = word(busReg);
        w.gra = 1'b1;
        w.mdrIn = 1'b1;
        drive(w);
        w = word(busNone);
        w.write = 1'b1;
        drive(w);
    end else begin
        w = word(busNone);
        w.read = 1'b1;
        w.mdrIn = 1'b1;
        drive(w);
        w = word(busMdr);
        w.gra = 1'b1;
        w.rIn = 1'b1;
        drive(w);
    end
endtask

task automatic testStoreLoad();
    logic [31:0] v;
    logic [31:0] got;
    v = $random(seed);
    regWrite(3, v);
    regWrite(4, 8);
    memAccess(1'b1, 3, 4, 40, 1'b0);
    memAccess(1'b0, 5, 4, 40, 1'b0);
    regRead(5, got);
    check("ld indexed", got, v);
    v = $random(seed);
    regWrite(3, v);
    regWrite(0, 32'h0000_0100);  // r0 must not count in base mode.
    memAccess(1'b1, 3, 0, 60, 1'b1);
    memAccess(1'b0, 6, 4, 52, 1'b0);  // r4 still holds 8, so this reads address 60.
    regRead(6, got);
    check("st absolute", got, v);
    memAccess(1'b0, 5, 0, 60, 1'b1);
    regRead(5, got);
    check("ld absolute", got, v);
    finishTest("storeLoad");
endtask

task automatic testBranch();
    ctrlWord_t   w;
    logic [31:0] vals [3];
    logic        exp;
    for (int c2 = 0; c2 < 4; c2++) begin
        vals[0] = 32'd0;
        vals[1] = ($random(seed) & 32'h7fff_ffff) | 32'd1;
        vals[2] = $random(seed) | 32'h8000_0000;
        for (int k = 0; k < 3; k++) begin
            regWrite(7, vals[k]);
            setIr(mkInstr(opcode_t'(24 + c2), 7, c2, 0));  // c2 is the low bits of rb.
            w = word(busReg);
            w.gra = 1'b1;
            w.conIn = 1'b1;
            drive(w);
            drive(word(busNone));
            case (c2)
                0:       exp = (vals[k] == 0);
                1:       exp = (vals[k] != 0);
                2:       exp = !vals[k][31];
                default: exp = vals[k][31];
            endcase
            check($sformatf("conFlag c2=%0d", c2), conFlag, exp);
        end
    end
    finishTest("branch");
endtask

task automatic testJal();
    ctrlWord_t   w;
    logic [31:0] target;
    logic [31:0] link;
    target = $random(seed);
    regWrite(9, target);
    loadMem(0, mkInstr(opJal, 8, 9, 0));
    w = word(busNone);
    w.pcIn = 1'b1;  // start the fetch from address 0.
    drive(w);
    runFetch();
    w = word(busPc);
    w.gra = 1'b1;
    w.rIn = 1'b1;
    drive(w);
    w = word(busReg);
    w.grb = 1'b1;
    w.pcIn = 1'b1;
    drive(w);
    drive(word(busPc));
    check("jal pc", busData, target);
    w = word(busReg);
    w.gra = 1'b1;
    drive(w);
    link = busData;
    check("jal link", link, 1);
    finishTest("jal");
endtask

task automatic testReset();
    ctrlWord_t w;
    regWrite(10, 32'h1234_5678);
    setIr(mkInstr(opBrnz, 10, 1, 0));
    w = word(busReg);
    w.gra = 1'b1;
    w.conIn = 1'b1;
    drive(w);
    applyReset();
    drive(word(busPc));
    check("reset pc", busData, 0);
    drive(word(busZLow));
    check("reset zLow", busData, 0);
    drive(word(busMdr));
    check("reset mdr", busData, 0);
    check("reset conFlag", conFlag, 0);
    finishTest("reset");
endtask

// ==== sim/dataPathTb.sv ====
`timescale 1ns/1ps

module dataPathTb;
    import cpuPkg::*;
    import ctrlPkg::*;

    localparam int timeoutNs = 200000;

    logic                 clock;
    logic                 rstN;
    ctrlWord_t            ctrl;
    logic                 loadEn;
    logic [8:0]           loadAddr;
    logic [wordWidth-1:0] loadData;
    logic [wordWidth-1:0] busData;
    logic                 conFlag;

    integer seed = 32'h7227_e745;
    int     errorCount = 0;
    int     testErrors = 0;
    int     testCount = 0;

    dataPath #(.memWords(memWordsDefault)) u_dataPath (
        .clock    (clock),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .busData  (busData),
        .conFlag  (conFlag)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // an idle control word that only selects a bus source.
    function automatic ctrlWord_t word(busSrc_t src);
        ctrlWord_t w;
        w = '0;
        w.busSrc = src;
        return w;
    endfunction

    // packs opcode, ra, rb and the 19-bit constant into one instruction word.
    function automatic logic [31:0] mkInstr(opcode_t op, int ra, int rb, int c);
        logic [31:0] w;
        w = {op, ra[3:0], rb[3:0], c[18:0]};
        return w;
    endfunction

    // expected 64-bit Z value for one ALU operation on a and b.
    function automatic logic [63:0] expAlu(aluOp_t op, logic [31:0] a, logic [31:0] b);
        logic [63:0] r;
        case (op)
            aluAdd:   r = {32'd0, a + b};
            aluSub:   r = {32'd0, a - b};
            aluAnd:   r = {32'd0, a & b};
            aluOr:    r = {32'd0, a | b};
            aluShr:   r = {32'd0, a >> (b % 32)};
            aluShl:   r = {32'd0, a << (b % 32)};
            aluNeg:   r = {32'd0, -b};
            aluNot:   r = {32'd0, ~b};
            aluMul:   r = 64'($signed(a)) * 64'($signed(b));
            default:  r = {32'd0, b + 32'd1};  // incPc.
        endcase
        return r;
    endfunction

    // one control step; the word is latched at the following rising edge.
    task automatic drive(ctrlWord_t w);
        @(posedge clock);
        ctrl <= w;
        @(negedge clock);  // bus is settled here.
    endtask

    task automatic loadMem(int addr, logic [31:0] data);
        @(posedge clock);
        ctrl     <= '0;
        loadEn   <= 1'b1;
        loadAddr <= addr[8:0];
        loadData <= data;
        @(posedge clock);
        loadEn   <= 1'b0;
        @(negedge clock);
    endtask

    task automatic check(string what, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s got %h, expected %h", $time, what, got, exp);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic finishTest(string name);
        testCount++;
        if (testErrors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, testErrors);
        end
        testErrors = 0;
    endtask

    task automatic applyReset();
        int guard;
        @(posedge clock);
        rstN <= 1'b0;
        ctrl <= '0;
        guard = 0;
        while (guard < 4) begin  // four cycles held low.
            @(posedge clock);
            guard++;
        end
        rstN <= 1'b1;
        @(negedge clock);
    endtask

    `include "dataPathTests.svh"

    initial begin
        rstN     = 1'b0;
        ctrl     = '0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        applyReset();
        testFetch();
        testAlu();
        testStoreLoad();
        testBranch();
        testJal();
        testReset();
        $display("%0d tests run, %0d errors", testCount, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(timeoutNs);
        $display("timeout: the test sequence did not complete in time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+sim
hw/cpuPkg.sv
hw/ctrlPkg.sv
hw/regFile.sv
hw/selectEncode.sv
hw/alu.sv
hw/conFf.sv
hw/memSubsystem.sv
hw/dataPath.sv
sim/dataPathTb.sv
